// ==== source/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// store queue geometry
`define LSU_SQ_DEPTH 8 // slots, keep a power of two
`define LSU_SQ_LOG 3 // log2 of depth, slot index width

// an index carries one extra wrap bit on top of LSU_SQ_LOG
// so a full queue and an empty queue can be told apart

// word datapath
`define LSU_ADDR_BITS 32 // word address, no byte offset
`define LSU_DATA_BITS 32 // one data word

// ids, markers and the occupancy count all use LSU_SQ_LOG+1 bits
// depth must equal 1 << LSU_SQ_LOG for the pointer wrap to line up

`endif

// ==== source/lsuPkg.sv ====
`default_nettype none

`include "lsu_params.svh"

package lsuPkg;

	// store queue position, msb is the wrap bit
	// ordering between two positions is taken from their difference
	typedef logic [`LSU_SQ_LOG:0] sqIdx_t;

	// occupancy, 0 up to and including depth
	typedef logic [`LSU_SQ_LOG:0] sqCount_t;

	typedef logic [`LSU_ADDR_BITS-1:0] addr_t; // word address
	typedef logic [`LSU_DATA_BITS-1:0] data_t; // data word

	// a store's id is the tail value at its dispatch
	// a load's marker is the tail value at its dispatch
	// stores from head up to the marker are older than the load

endpackage

`default_nettype wire

// ==== source/storeQueueCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module storeQueueCtrl (
	input  wire              clk,
	input  wire              reset_i,
	input  wire              dispatchSt_i, // allocate tail slot
	input  wire              commitSt_i, // retire head slot
	input  wire              headAddrValid_i, // head store has its address
	output lsuPkg::sqIdx_t   stqHead_o,
	output lsuPkg::sqIdx_t   stqTail_o,
	output lsuPkg::sqCount_t stqCount_o,
	output logic             stqFull_o,
	output logic             commitFire_o // commit accepted this cycle
);

	import lsuPkg::*;

	sqIdx_t   headReg; // oldest store
	sqIdx_t   tailReg; // next free slot
	sqCount_t countReg; // stores in flight
	logic     queueEmpty;

	assign queueEmpty   = (countReg == '0);
	assign stqFull_o    = (countReg == sqCount_t'(`LSU_SQ_DEPTH));
	assign commitFire_o = commitSt_i && !queueEmpty && headAddrValid_i; // accept only if ready

	assign stqHead_o  = headReg;
	assign stqTail_o  = tailReg;
	assign stqCount_o = countReg;

	// pointers wrap through the extra msb on their own
	always_ff @(posedge clk) begin
		if (reset_i) begin
			headReg  <= '0;
			tailReg  <= '0;
			countReg <= '0;
		end else begin
			if (dispatchSt_i) begin
				tailReg <= tailReg + 1'b1; // store takes old tail as id
			end
			if (commitFire_o) begin
				headReg <= headReg + 1'b1; // head store leaves
			end
			case ({dispatchSt_i, commitFire_o})
				2'b10:   countReg <= countReg + 1'b1;
				2'b01:   countReg <= countReg - 1'b1;
				default: countReg <= countReg; // none or both
			endcase
		end
	end

	// no room left for a new store
	dispatchWhileFull: assert property (
		@(posedge clk) disable iff (reset_i)
		dispatchSt_i |-> !stqFull_o
	) else $error("store dispatched into a full queue");

	// agen has to deliver the head store's address before commit
	commitNeedsAddr: assert property (
		@(posedge clk) disable iff (reset_i)
		commitSt_i |-> (headAddrValid_i && !queueEmpty)
	) else $error("store commit without a known head address");

endmodule

`default_nettype wire

// ==== source/storeQueueEntry.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module storeQueueEntry #(
	parameter int ENTRY_IDX = 0 // slot this entry sits in
) (
	input  wire            clk,
	input  wire            reset_i,
	input  wire            dispatchSt_i,
	input  wire lsuPkg::sqIdx_t stqTail_i,
	input  wire lsuPkg::sqIdx_t stqHead_i,
	input  wire            commitFire_i,
	input  wire            stExec_i,
	input  wire lsuPkg::sqIdx_t stExecId_i,
	input  wire lsuPkg::addr_t  stExecAddr_i,
	input  wire lsuPkg::data_t  stExecData_i,
	input  wire lsuPkg::addr_t  ldExecAddr_i, // load lookup address
	input  wire lsuPkg::sqIdx_t ldExecTail_i, // load marker
	output logic           fwdHit_o,
	output logic           addrValid_o,
	output lsuPkg::addr_t  entryAddr_o,
	output lsuPkg::data_t  entryData_o
);

	import lsuPkg::*;

	localparam logic [`LSU_SQ_LOG-1:0] slotIdx = ENTRY_IDX[`LSU_SQ_LOG-1:0];

	logic   validReg; // slot holds a store
	logic   addrValidReg; // store address known
	sqIdx_t entryIdReg; // full id incl wrap bit
	addr_t  addrReg;
	data_t  dataReg;
	logic   allocHit;
	logic   freeHit;
	logic   execHit;
	logic   olderThanLoad;
	sqIdx_t entryDist;
	sqIdx_t markerDist;

	assign allocHit = dispatchSt_i && (stqTail_i[`LSU_SQ_LOG-1:0] == slotIdx);
	assign freeHit  = commitFire_i && (stqHead_i[`LSU_SQ_LOG-1:0] == slotIdx);
	assign execHit  = stExec_i && validReg && (stExecId_i == entryIdReg);

	// age relative to head, marker behind head means nothing older is left
	assign entryDist     = entryIdReg - stqHead_i;
	assign markerDist    = ldExecTail_i - stqHead_i;
	assign olderThanLoad = (entryDist < markerDist) && (markerDist <= sqIdx_t'(`LSU_SQ_DEPTH));

	assign addrValid_o = validReg && addrValidReg;
	assign fwdHit_o    = addrValid_o && (addrReg == ldExecAddr_i) && olderThanLoad; // cam hit
	assign entryAddr_o = addrReg;
	assign entryData_o = dataReg;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			validReg     <= 1'b0;
			addrValidReg <= 1'b0;
		end else if (allocHit) begin
			validReg     <= 1'b1; // new store, address pending
			addrValidReg <= 1'b0;
		end else if (freeHit) begin
			validReg     <= 1'b0;
			addrValidReg <= 1'b0;
		end else if (execHit) begin
			addrValidReg <= 1'b1; // agen result arrived
		end
	end

	always_ff @(posedge clk) begin
		if (allocHit) begin
			entryIdReg <= stqTail_i;
		end
		if (execHit) begin
			addrReg <= stExecAddr_i;
			dataReg <= stExecData_i;
		end
	end

	// the id sent back by agen has to name the live store in this slot
	execToLiveStore: assert property (
		@(posedge clk) disable iff (reset_i)
		(stExec_i && stExecId_i[`LSU_SQ_LOG-1:0] == slotIdx) |-> execHit
	) else $error("store execute to an empty or stale queue slot");

endmodule

`default_nettype wire

// ==== source/storeQueueRead.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module storeQueueRead (
	input  wire                      clk,
	input  wire                      reset_i,
	input  wire                      ldExec_i,
	input  wire lsuPkg::sqIdx_t      ldExecTail_i, // load marker
	input  wire lsuPkg::data_t       ldMemData_i, // fallback data
	input  wire [`LSU_SQ_DEPTH-1:0]  fwdHit_i, // per slot match
	input  wire lsuPkg::addr_t       entryAddr_i [`LSU_SQ_DEPTH],
	input  wire lsuPkg::data_t       entryData_i [`LSU_SQ_DEPTH],
	input  wire                      commitFire_i,
	input  wire lsuPkg::sqIdx_t      stqHead_i,
	output logic                     ldValid_o,
	output lsuPkg::data_t            ldData_o,
	output logic                     ldFwd_o,
	output logic                     stWrValid_o,
	output lsuPkg::addr_t            stWrAddr_o,
	output lsuPkg::data_t            stWrData_o
);

	import lsuPkg::*;

	sqIdx_t                      rotIdx [`LSU_SQ_DEPTH]; // slot behind marker by k+1
	logic [`LSU_SQ_DEPTH-1:0]    hitRot; // bit 0 is youngest older slot
	logic [`LSU_SQ_LOG-1:0]      fwdSel; // winning slot
	logic                        fwdAny;
	logic [`LSU_SQ_LOG-1:0]      headSlot;

	// rotate so hits line up youngest first
	always_comb begin
		for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
			rotIdx[k] = ldExecTail_i - sqIdx_t'(k + 1);
			hitRot[k] = fwdHit_i[rotIdx[k][`LSU_SQ_LOG-1:0]];
		end
	end

	// priority pick, lowest rotated bit wins
	always_comb begin
		fwdAny = |hitRot;
		fwdSel = '0;
		for (int k = `LSU_SQ_DEPTH - 1; k >= 0; k--) begin
			if (hitRot[k]) begin
				fwdSel = rotIdx[k][`LSU_SQ_LOG-1:0];
			end
		end
	end

	assign headSlot = stqHead_i[`LSU_SQ_LOG-1:0];

	// load result, one cycle after execute
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ldValid_o <= 1'b0;
			ldFwd_o   <= 1'b0;
		end else begin
			ldValid_o <= ldExec_i;
			if (ldExec_i) begin
				ldFwd_o <= fwdAny;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ldExec_i) begin
			ldData_o <= fwdAny ? entryData_i[fwdSel] : ldMemData_i; // sq beats memory
		end
	end

	// commit write-out of the head store
	always_ff @(posedge clk) begin
		if (reset_i) begin
			stWrValid_o <= 1'b0;
		end else begin
			stWrValid_o <= commitFire_i;
		end
	end

	always_ff @(posedge clk) begin
		if (commitFire_i) begin
			stWrAddr_o <= entryAddr_i[headSlot];
			stWrData_o <= entryData_i[headSlot];
		end
	end

endmodule

`default_nettype wire

// ==== source/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module loadStoreUnit (
	input  wire                 clk,
	input  wire                 reset_i,
	input  wire                 dispatchSt_i,
	input  wire                 stExec_i,
	input  wire lsuPkg::sqIdx_t stExecId_i,
	input  wire lsuPkg::addr_t  stExecAddr_i,
	input  wire lsuPkg::data_t  stExecData_i,
	input  wire                 ldExec_i,
	input  wire lsuPkg::addr_t  ldExecAddr_i,
	input  wire lsuPkg::sqIdx_t ldExecTail_i,
	input  wire lsuPkg::data_t  ldMemData_i,
	input  wire                 commitSt_i,
	output lsuPkg::sqIdx_t      stqTail_o, // id for next store, marker for loads
	output lsuPkg::sqCount_t    stqCount_o,
	output logic                stqFull_o,
	output logic                ldValid_o,
	output lsuPkg::data_t       ldData_o,
	output logic                ldFwd_o,
	output logic                stWrValid_o,
	output lsuPkg::addr_t       stWrAddr_o,
	output lsuPkg::data_t       stWrData_o
);

	import lsuPkg::*;

	sqIdx_t                   stqHead;
	logic                     commitFire;
	logic                     headAddrValid;
	logic [`LSU_SQ_DEPTH-1:0] fwdHit; // cam result per slot
	logic [`LSU_SQ_DEPTH-1:0] addrValid;
	addr_t                    entryAddr [`LSU_SQ_DEPTH];
	data_t                    entryData [`LSU_SQ_DEPTH];

	assign headAddrValid = addrValid[stqHead[`LSU_SQ_LOG-1:0]]; // head slot ready to commit

	storeQueueCtrl ctrl0 (
		.clk             (clk),
		.reset_i         (reset_i),
		.dispatchSt_i    (dispatchSt_i),
		.commitSt_i      (commitSt_i),
		.headAddrValid_i (headAddrValid),
		.stqHead_o       (stqHead),
		.stqTail_o       (stqTail_o),
		.stqCount_o      (stqCount_o),
		.stqFull_o       (stqFull_o),
		.commitFire_o    (commitFire)
	);

	for (genvar i = 0; i < `LSU_SQ_DEPTH; i++) begin : genEntry
		storeQueueEntry #(
			.ENTRY_IDX (i)
		) sqEntry (
			.clk          (clk),
			.reset_i      (reset_i),
			.dispatchSt_i (dispatchSt_i),
			.stqTail_i    (stqTail_o),
			.stqHead_i    (stqHead),
			.commitFire_i (commitFire),
			.stExec_i     (stExec_i),
			.stExecId_i   (stExecId_i),
			.stExecAddr_i (stExecAddr_i),
			.stExecData_i (stExecData_i),
			.ldExecAddr_i (ldExecAddr_i),
			.ldExecTail_i (ldExecTail_i),
			.fwdHit_o     (fwdHit[i]),
			.addrValid_o  (addrValid[i]),
			.entryAddr_o  (entryAddr[i]),
			.entryData_o  (entryData[i])
		);
	end

	storeQueueRead read0 (
		.clk          (clk),
		.reset_i      (reset_i),
		.ldExec_i     (ldExec_i),
		.ldExecTail_i (ldExecTail_i),
		.ldMemData_i  (ldMemData_i),
		.fwdHit_i     (fwdHit),
		.entryAddr_i  (entryAddr),
		.entryData_i  (entryData),
		.commitFire_i (commitFire),
		.stqHead_i    (stqHead),
		.ldValid_o    (ldValid_o),
		.ldData_o     (ldData_o),
		.ldFwd_o      (ldFwd_o),
		.stWrValid_o  (stWrValid_o),
		.stWrAddr_o   (stWrAddr_o),
		.stWrData_o   (stWrData_o)
	);

endmodule

`default_nettype wire

// ==== testbench/lsuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTb;

	import lsuPkg::*;

	localparam int maxOps = 128;

	logic     clk;
	logic     reset_i;
	logic     dispatchSt_i;
	logic     stExec_i;
	sqIdx_t   stExecId_i;
	addr_t    stExecAddr_i;
	data_t    stExecData_i;
	logic     ldExec_i;
	addr_t    ldExecAddr_i;
	sqIdx_t   ldExecTail_i;
	data_t    ldMemData_i;
	logic     commitSt_i;
	sqIdx_t   stqTail_o;
	sqCount_t stqCount_o;
	logic     stqFull_o;
	logic     ldValid_o;
	data_t    ldData_o;
	logic     ldFwd_o;
	logic     stWrValid_o;
	addr_t    stWrAddr_o;
	data_t    stWrData_o;

	string       opCode [maxOps]; // upper case gets a random gap
	string       testName [maxOps];
	logic [31:0] opArg [maxOps][5];
	int          numOps = 0;
	int          fileLines = 0;
	int          cycleCount = 0;
	int          cycleLimit = 1000; // replaced once the file is read
	int          errCount = 0;
	int          passCount = 0;
	int          failCount = 0;
	logic [31:0] rngState;
	sqIdx_t      modelHead; // pointers as issued, for marker legality
	sqIdx_t      modelTail;
	int          pendKind = 0; // 0 none, 1 load, 2 commit write
	int          pendIdx;
	logic        pendBad;
	data_t       pendData;
	addr_t       pendAddr;
	logic        pendFwd;

	loadStoreUnit dut0 (
		.clk          (clk),
		.reset_i      (reset_i),
		.dispatchSt_i (dispatchSt_i),
		.stExec_i     (stExec_i),
		.stExecId_i   (stExecId_i),
		.stExecAddr_i (stExecAddr_i),
		.stExecData_i (stExecData_i),
		.ldExec_i     (ldExec_i),
		.ldExecAddr_i (ldExecAddr_i),
		.ldExecTail_i (ldExecTail_i),
		.ldMemData_i  (ldMemData_i),
		.commitSt_i   (commitSt_i),
		.stqTail_o    (stqTail_o),
		.stqCount_o   (stqCount_o),
		.stqFull_o    (stqFull_o),
		.ldValid_o    (ldValid_o),
		.ldData_o     (ldData_o),
		.ldFwd_o      (ldFwd_o),
		.stWrValid_o  (stWrValid_o),
		.stWrAddr_o   (stWrAddr_o),
		.stWrData_o   (stWrData_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("run stopped after %0d cycles without finishing", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkData(input string name, input data_t expVal, input data_t actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH %s data expected %h actual %h", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic checkAddr(input string name, input addr_t expVal, input addr_t actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH %s addr expected %h actual %h", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic checkCount(input string name, input sqCount_t expVal, input sqCount_t actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH %s count expected %0d actual %0d", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic checkIdx(input string name, input sqIdx_t expVal, input sqIdx_t actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH %s id expected %h actual %h", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH %s flag expected %b actual %b", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic reportTest(input int idx, input logic bad);
		if (bad) begin
			failCount++;
			$display("FAIL %s", testName[idx]);
		end else begin
			passCount++;
			$display("ok   %s", testName[idx]);
		end
	endtask

	task automatic loadTests;
		int               fd;
		int               got;
		string            op;
		string            name;
		logic [31:0]      a0, a1, a2, a3, a4;
		logic [8*160-1:0] lineBuf;
		fd = $fopen("testbench/lsu_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/lsu_tests.txt");
			errCount++;
		end else begin
			while (!$feof(fd) && numOps < maxOps) begin
				lineBuf = '0;
				if ($fgets(lineBuf, fd) != 0) begin
					fileLines++;
					got = $sscanf(lineBuf, "%s %s %h %h %h %h %h",
						op, name, a0, a1, a2, a3, a4);
					if (got == 7 && op.substr(0, 0) != "#") begin // skip comments
						opCode[numOps]   = op;
						testName[numOps] = name;
						opArg[numOps][0] = a0;
						opArg[numOps][1] = a1;
						opArg[numOps][2] = a2;
						opArg[numOps][3] = a3;
						opArg[numOps][4] = a4;
						numOps++;
					end
				end
			end
			$fclose(fd);
			if (numOps == 0) begin
				$display("test file holds no operations");
				errCount++;
			end
		end
	endtask

	task automatic clearInputs;
		dispatchSt_i <= 1'b0;
		stExec_i     <= 1'b0;
		ldExec_i     <= 1'b0;
		commitSt_i   <= 1'b0;
	endtask

	// results of the op driven one edge earlier are stable now
	task automatic finishPending;
		int base;
		base = errCount;
		if (pendKind != 1 && ldValid_o) begin
			$display("load result pulse with no load outstanding");
			errCount++;
		end
		if (pendKind != 2 && stWrValid_o) begin
			$display("store write-out pulse with no commit outstanding");
			errCount++;
		end
		if (pendKind == 1) begin
			if (!ldValid_o) begin
				$display("%s got no load result one cycle after execute", testName[pendIdx]);
				errCount++;
			end else begin
				checkData(testName[pendIdx], pendData, ldData_o);
				checkFlag(testName[pendIdx], pendFwd, ldFwd_o);
			end
		end else if (pendKind == 2) begin
			if (!stWrValid_o) begin
				$display("%s got no store write-out after commit", testName[pendIdx]);
				errCount++;
			end else begin
				checkAddr(testName[pendIdx], pendAddr, stWrAddr_o);
				checkData(testName[pendIdx], pendData, stWrData_o);
			end
		end
		if (pendKind != 0) begin
			reportTest(pendIdx, pendBad || (errCount != base));
		end
		pendKind = 0;
	endtask

	task automatic idleCycle;
		@(posedge clk);
		clearInputs();
		@(negedge clk);
		finishPending();
	endtask

	task automatic runOp(input int idx);
		string kind;
		string name;
		int    base;
		logic  bad;
		kind = opCode[idx].toupper();
		name = testName[idx];
		bad  = 1'b0;
		@(posedge clk);
		clearInputs();
		if (kind == "D" || kind == "B") begin
			dispatchSt_i <= 1'b1;
			modelTail = modelTail + 1'b1;
		end
		if (kind == "C" || kind == "B") begin
			commitSt_i <= 1'b1;
			modelHead = modelHead + 1'b1;
		end
		if (kind == "E") begin
			stExec_i     <= 1'b1;
			stExecId_i   <= sqIdx_t'(opArg[idx][0]);
			stExecAddr_i <= addr_t'(opArg[idx][1]);
			stExecData_i <= data_t'(opArg[idx][2]);
		end
		if (kind == "L") begin
			// marker must sit between head and tail
			if (sqIdx_t'(sqIdx_t'(opArg[idx][1]) - modelHead) > sqIdx_t'(modelTail - modelHead)) begin
				$display("%s uses a marker outside the live queue", name);
				errCount++;
				bad = 1'b1;
			end
			ldExec_i     <= 1'b1;
			ldExecAddr_i <= addr_t'(opArg[idx][0]);
			ldExecTail_i <= sqIdx_t'(opArg[idx][1]);
			ldMemData_i  <= data_t'(opArg[idx][2]);
		end
		@(negedge clk);
		finishPending();
		base = errCount;
		if (kind == "D" || kind == "B") begin
			checkIdx(name, sqIdx_t'(opArg[idx][0]), stqTail_o); // tail not yet moved
		end
		if (kind == "N") begin
			checkCount(name, sqCount_t'(opArg[idx][0]), stqCount_o);
			checkFlag(name, opArg[idx][1][0], stqFull_o);
		end
		bad = bad || (errCount != base);
		pendIdx = idx;
		pendBad = bad;
		if (kind == "L") begin
			pendKind = 1;
			pendData = data_t'(opArg[idx][3]);
			pendFwd  = opArg[idx][4][0];
		end else if (kind == "C") begin
			pendKind = 2;
			pendAddr = addr_t'(opArg[idx][0]);
			pendData = data_t'(opArg[idx][1]);
		end else if (kind == "B") begin
			pendKind = 2;
			pendAddr = addr_t'(opArg[idx][1]);
			pendData = data_t'(opArg[idx][2]);
		end else begin
			reportTest(idx, bad);
		end
	endtask

	initial begin
		int    gap;
		string op;
		reset_i      = 1'b1;
		dispatchSt_i = 1'b0;
		stExec_i     = 1'b0;
		stExecId_i   = '0;
		stExecAddr_i = '0;
		stExecData_i = '0;
		ldExec_i     = 1'b0;
		ldExecAddr_i = '0;
		ldExecTail_i = '0;
		ldMemData_i  = '0;
		commitSt_i   = 1'b0;
		rngState     = 32'h9d98_905d;
		modelHead    = '0;
		modelTail    = '0;
		loadTests();
		cycleLimit = 4 * fileLines + 20;
		repeat (3) @(posedge clk);
		reset_i <= 1'b0;
		for (int i = 0; i < numOps; i++) begin
			op = opCode[i];
			if (op == op.toupper()) begin // lower case means back to back
				rngState = xorshift(rngState);
				gap = int'(rngState % 3);
				repeat (gap) idleCycle();
			end
			runOp(i);
		end
		idleCycle(); // drain last result
		idleCycle();
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			numOps, passCount, failCount, errCount);
		if (errCount == 0 && failCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/lsuPkg.sv
source/storeQueueCtrl.sv
source/storeQueueEntry.sv
source/storeQueueRead.sv
source/loadStoreUnit.sv
testbench/lsuTb.sv

// ==== Makefile ====
# Verilator build and run for the store queue testbench

VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASSMSG   ?= TEST PASSED

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all run build lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$($(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^$(PASSMSG)$$'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== testbench/lsu_tests.txt ====
# columns: op name a0 a1 a2 a3 a4 (hex), a lower-case op runs with no idle gap before it
# D id | E id addr data | L addr marker mem expData expFwd | C addr data | B id addr data | N count full
N cntReset  0   0 0        0        0
L ldEmpty   100 0 aaaa0001 aaaa0001 0
D st0       0   0 0        0        0
D st1       1   0 0        0        0
D st2       2   0 0        0        0
N cnt3      3   0 0        0        0
E ex0       0   100 11110000 0      0
L ldUnknown 200 3 bbbb0002 bbbb0002 0
E ex1       1   200 22220001 0      0
L ldKnown   200 3 bbbb0003 22220001 1
E ex2       2   200 22220002 0      0
L ldYoung   200 3 bbbb0004 22220002 1
l ldSkipYng 200 2 bbbb0005 22220001 1
l ldOld     100 1 bbbb0006 11110000 1
l ldNoOlder 100 0 bbbb0007 bbbb0007 0
C cm0       100 11110000 0 0        0
L ldGone    100 3 bbbb0008 bbbb0008 0
C cm1       200 22220001 0 0        0
N cnt1      1   0 0        0        0
L ldAfterCm 200 3 bbbb0009 22220002 1
D st3       3   0 0        0        0
D st4       4   0 0        0        0
D st5       5   0 0        0        0
D st6       6   0 0        0        0
D st7       7   0 0        0        0
D st8       8   0 0        0        0
D st9       9   0 0        0        0
N cntFull   8   1 0        0        0
E ex8       8   300 88880000 0      0
E ex3       3   300 33330000 0      0
L ldWrapA   300 a cccc0001 88880000 1
l ldWrapB   300 8 cccc0002 33330000 1
l ldWrapMem 400 a cccc0003 cccc0003 0
C cm2       200 22220002 0 0        0
B dcBoth    a   300 33330000 0      0
N cnt7      7   0 0        0        0
